/* common/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width of the core.
`define XLEN 32

// width of a register index.
`define REG_ADDR_WIDTH 5

// first fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes, taken from inst[6:0].
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_FENCE  = 7'b0001111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// funct3 of the OP and OP_IMM groups.
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 of the branch compares.
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* common/core_pkg.sv */
`include "rv_config.svh"

package core_pkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	// operand A is the pc when a_pc is set, operand B the immediate when b_imm is set.
	typedef struct packed {
		logic a_pc;
		logic b_imm;
	} src_sel_e;

	typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH} npc_kind_e;

	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] rs1;
		logic [`REG_ADDR_WIDTH-1:0] rs2;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic                       rd_wen;
		logic [`XLEN-1:0]           imm;
		alu_op_e                    alu_op;
		src_sel_e                   src_sel;
		npc_kind_e                  npc_kind;
		logic [2:0]                 funct3;
	} dec_t;

	typedef struct packed {
		logic [`XLEN-1:0]           pc;
		logic [`XLEN-1:0]           next_pc;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic                       rd_wen;
		logic [`XLEN-1:0]           wdata;
	} retire_t;

endpackage

/* design/decode/rv_op_decoder.sv */
`timescale 1ns/100ps

module rv_op_decoder (
	input  rv_isa_pkg::opcode_e        opcode,
	input  logic [2:0]                 funct3,
	input  logic                       funct7_b5,
	output core_pkg::alu_op_e          alu_op,
	output core_pkg::src_sel_e         src_sel,
	output core_pkg::npc_kind_e        npc_kind
);

	// alt picks SUB over ADD and SRA over SRL.
	function automatic core_pkg::alu_op_e func_op(input logic [2:0] f3, input logic alt);
		core_pkg::alu_op_e op;
		op = core_pkg::ALU_ADD;
		case (f3)
			rv_isa_pkg::F3_ADD_SUB: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:     op = core_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:     op = core_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU:    op = core_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:     op = core_pkg::ALU_XOR;
			rv_isa_pkg::F3_SRL_SRA: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:      op = core_pkg::ALU_OR;
			rv_isa_pkg::F3_AND:     op = core_pkg::ALU_AND;
			default:                op = core_pkg::ALU_ADD;
		endcase
		return op;
	endfunction

	always_comb begin
		alu_op   = core_pkg::ALU_ADD;
		src_sel  = '0;
		npc_kind = core_pkg::NPC_SEQ;
		case (opcode)
			rv_isa_pkg::OPC_LUI: begin
				alu_op        = core_pkg::ALU_PASS_B;
				src_sel.b_imm = 1'b1;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				src_sel.a_pc  = 1'b1;
				src_sel.b_imm = 1'b1;
			end
			rv_isa_pkg::OPC_JAL: begin
				src_sel.a_pc  = 1'b1;
				src_sel.b_imm = 1'b1;
				npc_kind      = core_pkg::NPC_JAL;
			end
			rv_isa_pkg::OPC_JALR: begin
				src_sel.b_imm = 1'b1;
				npc_kind      = core_pkg::NPC_JALR;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				npc_kind = core_pkg::NPC_BRANCH;
				case (funct3)
					rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE:   alu_op = core_pkg::ALU_SLT;
					rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU: alu_op = core_pkg::ALU_SLTU;
					default:                                  alu_op = core_pkg::ALU_SUB;
				endcase
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				src_sel.b_imm = 1'b1;
				alu_op = func_op(funct3, (funct3 == rv_isa_pkg::F3_SRL_SRA) && funct7_b5);
			end
			rv_isa_pkg::OPC_OP: alu_op = func_op(funct3, funct7_b5);
			default: ;
		endcase
	end

endmodule

/* design/decode/rv_decoder.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_decoder (
	input  logic [`XLEN-1:0] inst,
	output core_pkg::dec_t   dec
);

	rv_isa_pkg::opcode_e        opcode;
	logic [2:0]                 funct3;
	logic [`REG_ADDR_WIDTH-1:0] rs1_f;
	logic [`REG_ADDR_WIDTH-1:0] rs2_f;
	logic [`REG_ADDR_WIDTH-1:0] rd_f;
	logic [`XLEN-1:0]           imm_i;
	logic [`XLEN-1:0]           imm_s;
	logic [`XLEN-1:0]           imm_b;
	logic [`XLEN-1:0]           imm_u;
	logic [`XLEN-1:0]           imm_j;
	logic                       known;
	core_pkg::alu_op_e          alu_op;
	core_pkg::src_sel_e         src_sel;
	core_pkg::npc_kind_e        npc_kind;

	assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign rs1_f  = inst[19:15];
	assign rs2_f  = inst[24:20];
	assign rd_f   = inst[11:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'd0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	rv_op_decoder u_op_decoder (
		.opcode    (opcode),
		.funct3    (funct3),
		.funct7_b5 (inst[30]),
		.alu_op    (alu_op),
		.src_sel   (src_sel),
		.npc_kind  (npc_kind)
	);

	// anything not listed stays an all-zero bundle and retires as a no-op.
	always_comb begin
		dec   = '0;
		known = 1'b1;
		case (opcode)
			rv_isa_pkg::OPC_LUI,
			rv_isa_pkg::OPC_AUIPC: begin
				dec.rd     = rd_f;
				dec.rd_wen = 1'b1;
				dec.imm    = imm_u;
			end
			rv_isa_pkg::OPC_JAL: begin
				dec.rd     = rd_f;
				dec.rd_wen = 1'b1;
				dec.imm    = imm_j;
			end
			rv_isa_pkg::OPC_JALR,
			rv_isa_pkg::OPC_OP_IMM: begin
				dec.rs1    = rs1_f;
				dec.rd     = rd_f;
				dec.rd_wen = 1'b1;
				dec.imm    = imm_i;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				dec.rs1 = rs1_f;
				dec.rs2 = rs2_f;
				dec.imm = imm_b;
			end
			// stores have no write and a sequential next pc, so they still retire as no-ops.
			rv_isa_pkg::OPC_STORE: begin
				dec.rs1 = rs1_f;
				dec.rs2 = rs2_f;
				dec.imm = imm_s;
			end
			rv_isa_pkg::OPC_OP: begin
				dec.rs1    = rs1_f;
				dec.rs2    = rs2_f;
				dec.rd     = rd_f;
				dec.rd_wen = 1'b1;
			end
			default: known = 1'b0;
		endcase
		if (known) begin
			dec.alu_op   = alu_op;
			dec.src_sel  = src_sel;
			dec.npc_kind = npc_kind;
			dec.funct3   = funct3;
		end
	end

endmodule

/* design/reg_file.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module reg_file (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`REG_ADDR_WIDTH-1:0] rs1,
	input  logic [`REG_ADDR_WIDTH-1:0] rs2,
	output logic [`XLEN-1:0]           rs1_data,
	output logic [`XLEN-1:0]           rs2_data,
	input  logic                       wr_en,
	input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
	input  logic [`XLEN-1:0]           wr_data
);

	localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

	logic [`XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/alu.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module alu (
	input  core_pkg::alu_op_e alu_op,
	input  logic [2:0]        funct3,
	input  logic [`XLEN-1:0]  a,
	input  logic [`XLEN-1:0]  b,
	output logic [`XLEN-1:0]  result,
	output logic              branch_taken
);

	localparam int SHW = $clog2(`XLEN);

	logic [SHW-1:0] shamt;
	logic           lt_s;
	logic           lt_u;

	assign shamt = b[SHW-1:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (alu_op)
			core_pkg::ALU_ADD:    result = a + b;
			core_pkg::ALU_SUB:    result = a - b;
			core_pkg::ALU_SLL:    result = a << shamt;
			core_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_s};
			core_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_u};
			core_pkg::ALU_XOR:    result = a ^ b;
			core_pkg::ALU_SRL:    result = a >> shamt;
			core_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
			core_pkg::ALU_OR:     result = a | b;
			core_pkg::ALU_AND:    result = a & b;
			core_pkg::ALU_PASS_B: result = b;
			default:              result = '0;
		endcase
	end

	// only meaningful when the instruction is a branch.
	always_comb begin
		case (funct3)
			rv_isa_pkg::F3_BEQ:  branch_taken = (a == b);
			rv_isa_pkg::F3_BNE:  branch_taken = (a != b);
			rv_isa_pkg::F3_BLT:  branch_taken = lt_s;
			rv_isa_pkg::F3_BGE:  branch_taken = !lt_s;
			rv_isa_pkg::F3_BLTU: branch_taken = lt_u;
			rv_isa_pkg::F3_BGEU: branch_taken = !lt_u;
			default:             branch_taken = 1'b0;
		endcase
	end

endmodule

/* design/core_ctrl.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module core_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	output logic                       imem_req,
	output logic [`XLEN-1:0]           imem_addr,
	input  logic                       imem_ack,
	input  logic [`XLEN-1:0]           imem_rdata,
	output logic [`XLEN-1:0]           inst,
	input  core_pkg::dec_t             dec,
	input  logic [`XLEN-1:0]           alu_result,
	input  logic                       branch_taken,
	input  logic [`XLEN-1:0]           rs1_data,
	output logic [`XLEN-1:0]           pc,
	output logic                       wr_en,
	output logic [`REG_ADDR_WIDTH-1:0] wr_addr,
	output logic [`XLEN-1:0]           wr_data,
	output logic                       retire_valid,
	output core_pkg::retire_t          retire
);

	typedef enum logic [1:0] {REQ, WAIT_ACK_LOW, EXEC} state_e;

	state_e           state;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] pc_plus_imm;
	logic [`XLEN-1:0] jalr_target;
	logic [`XLEN-1:0] next_pc;
	logic [`XLEN-1:0] wdata;

	// four-phase fetch. The request only rises once the previous ack has dropped.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= REQ;
			imem_req <= 1'b0;
			pc       <= `RESET_PC;
		end else begin
			case (state)
				REQ: begin
					if (imem_req && imem_ack) begin
						imem_req <= 1'b0;
						state    <= WAIT_ACK_LOW;
					end else if (!imem_req && !imem_ack) begin
						imem_req <= 1'b1;
					end
				end
				WAIT_ACK_LOW: begin
					if (!imem_ack) begin
						state <= EXEC;
					end
				end
				EXEC: begin
					pc    <= next_pc;
					state <= REQ;
				end
				default: state <= REQ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == REQ && imem_req && imem_ack) begin
			inst <= imem_rdata;
		end
	end

	assign imem_addr   = pc;
	assign pc_plus4    = pc + `XLEN'd4;
	assign pc_plus_imm = pc + dec.imm;
	assign jalr_target = (rs1_data + dec.imm) & ~`XLEN'd1;

	always_comb begin
		case (dec.npc_kind)
			core_pkg::NPC_JAL:    next_pc = pc_plus_imm;
			core_pkg::NPC_JALR:   next_pc = jalr_target;
			core_pkg::NPC_BRANCH: next_pc = branch_taken ? pc_plus_imm : pc_plus4;
			default:              next_pc = pc_plus4;
		endcase
	end

	// jumps link the return address, everything else writes the ALU result.
	assign wdata = (dec.npc_kind == core_pkg::NPC_JAL || dec.npc_kind == core_pkg::NPC_JALR) ?
		pc_plus4 : alu_result;

	assign retire_valid = (state == EXEC);
	assign wr_en        = retire_valid && dec.rd_wen;
	assign wr_addr      = dec.rd;
	assign wr_data      = wdata;

	assign retire.pc      = pc;
	assign retire.next_pc = next_pc;
	assign retire.rd      = dec.rd;
	assign retire.rd_wen  = dec.rd_wen;
	assign retire.wdata   = wdata;

endmodule

/* design/core_top.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module core_top (
	input  logic              clk,
	input  logic              rst_n,
	output logic              imem_req,
	output logic [`XLEN-1:0]  imem_addr,
	input  logic              imem_ack,
	input  logic [`XLEN-1:0]  imem_rdata,
	output logic              retire_valid,
	output core_pkg::retire_t retire
);

	logic [`XLEN-1:0]           inst;
	core_pkg::dec_t             dec;
	logic [`XLEN-1:0]           pc;
	logic [`XLEN-1:0]           rs1_data;
	logic [`XLEN-1:0]           rs2_data;
	logic [`XLEN-1:0]           alu_a;
	logic [`XLEN-1:0]           alu_b;
	logic [`XLEN-1:0]           alu_result;
	logic                       branch_taken;
	logic                       wr_en;
	logic [`REG_ADDR_WIDTH-1:0] wr_addr;
	logic [`XLEN-1:0]           wr_data;

	core_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_req     (imem_req),
		.imem_addr    (imem_addr),
		.imem_ack     (imem_ack),
		.imem_rdata   (imem_rdata),
		.inst         (inst),
		.dec          (dec),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.rs1_data     (rs1_data),
		.pc           (pc),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	rv_decoder u_decoder (
		.inst (inst),
		.dec  (dec)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (dec.rs1),
		.rs2      (dec.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	assign alu_a = dec.src_sel.a_pc ? pc : rs1_data;
	assign alu_b = dec.src_sel.b_imm ? dec.imm : rs2_data;

	alu u_alu (
		.alu_op       (dec.alu_op),
		.funct3       (dec.funct3),
		.a            (alu_a),
		.b            (alu_b),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

endmodule

/* test/tb_core.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module tb_core;

	localparam int NUM_INSTS  = 300;
	localparam int WAIT_LIMIT = 40;
	localparam int RUN_LIMIT  = NUM_INSTS * 20;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              imem_req;
	logic [`XLEN-1:0]  imem_addr;
	logic              imem_ack;
	logic [`XLEN-1:0]  imem_rdata;
	logic              retire_valid;
	core_pkg::retire_t retire;

	logic [31:0] lfsr = 32'h0a54_83a7;
	logic [31:0] fetched_inst = '0;
	logic        hung = 1'b0;
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;
	logic        was_reset = 1'b0;
	logic        prev_req;
	logic        prev_ack;
	logic        prev_retire;
	logic [31:0] prev_addr;
	int          pending;
	int          fetches;
	int          retired = 0;
	int          value_errors = 0;
	int          protocol_errors = 0;

	core_top u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_req     (imem_req),
		.imem_addr    (imem_addr),
		.imem_ack     (imem_ack),
		.imem_rdata   (imem_rdata),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	always #5 clk = ~clk;

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// only x0 to x7 are used so that results are read back and x0 is written now and then.
	function automatic logic [31:0] make_inst();
		logic [2:0]  kind;
		logic [2:0]  f3;
		logic [2:0]  bf3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  r5;
		logic        alt;
		logic [19:0] u20;
		logic [11:0] i12;
		logic [6:0]  f7;
		logic [12:0] bo;
		logic [20:0] jo;
		kind = 3'(rand_bits(3));
		rd   = 5'(rand_bits(3));
		rs1  = 5'(rand_bits(3));
		rs2  = 5'(rand_bits(3));
		f3   = 3'(rand_bits(3));
		alt  = 1'(rand_bits(1));
		r5   = 5'(rand_bits(5));
		u20  = 20'(rand_bits(20));
		if (f3 == 3'd1) begin
			i12 = {7'd0, r5};
		end else if (f3 == 3'd5) begin
			i12 = {1'b0, alt, 5'd0, r5};
		end else begin
			i12 = 12'(rand_bits(12));
		end
		f7  = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, alt, 5'd0} : 7'd0;
		bf3 = (f3 == 3'd2 || f3 == 3'd3) ? f3 + 3'd2 : f3;
		bo  = 13'((rand_bits(3) + 32'd1) << 2);
		jo  = {{14{r5[4]}}, r5, 2'b00};
		case (kind)
			3'd0: return {u20, rd, OPC_LUI};
			3'd1: return {u20, rd, OPC_AUIPC};
			3'd3: return {f7, rs2, rs1, f3, rd, OPC_OP};
			3'd4: return {bo[12], bo[10:5], rs2, rs1, bf3, bo[4:1], bo[11], OPC_BRANCH};
			3'd5: return {jo[20], jo[10:1], jo[11], jo[19:12], rd, OPC_JAL};
			3'd6: return {{7{r5[4]}}, r5, rs1, 3'b000, rd, OPC_JALR};
			default: return {i12, rs1, f3, rd, OPC_OP_IMM};
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic model_exec(input logic [31:0] in, output logic wen, output logic [4:0] rd,
			output logic [31:0] wdata, output logic [31:0] npc);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		a     = model_regs[in[19:15]];
		b     = model_regs[in[24:20]];
		imm_i = {{20{in[31]}}, in[31:20]};
		imm_u = {in[31:12], 12'd0};
		imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
		imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
		wen   = 1'b1;
		rd    = in[11:7];
		wdata = '0;
		npc   = model_pc + 32'd4;
		case (in[6:0])
			OPC_LUI:    wdata = imm_u;
			OPC_AUIPC:  wdata = model_pc + imm_u;
			OPC_JAL: begin
				wdata = model_pc + 32'd4;
				npc   = model_pc + imm_j;
			end
			OPC_JALR: begin
				wdata = model_pc + 32'd4;
				npc   = (a + imm_i) & ~32'd1;
			end
			OPC_OP_IMM: wdata = alu_ref(in[14:12], in[30] && in[14:12] == 3'd5, a, imm_i);
			OPC_OP:     wdata = alu_ref(in[14:12], in[30], a, b);
			default: begin
				wen = 1'b0;
				rd  = '0;
				if (in[6:0] == OPC_BRANCH && branch_ref(in[14:12], a, b)) begin
					npc = model_pc + imm_b;
				end
			end
		endcase
	endtask

	task automatic value_fail(input string what, input logic [31:0] got, input logic [31:0] exp);
		value_errors++;
		$display("MISMATCH at %0t: %s is %h, expected %h (inst %h)", $time, what, got, exp,
			fetched_inst);
	endtask

	task automatic protocol_fail(input string what);
		protocol_errors++;
		$display("protocol error at %0t: %s", $time, what);
	endtask

	task automatic check_retire();
		logic        e_wen;
		logic [4:0]  e_rd;
		logic [31:0] e_wdata;
		logic [31:0] e_npc;
		model_exec(fetched_inst, e_wen, e_rd, e_wdata, e_npc);
		assert (retire.pc == model_pc) else value_fail("retire pc", retire.pc, model_pc);
		assert (retire.rd_wen == e_wen)
			else value_fail("rd_wen", 32'(retire.rd_wen), 32'(e_wen));
		assert (retire.rd == e_rd) else value_fail("rd", 32'(retire.rd), 32'(e_rd));
		if (e_wen) begin
			assert (retire.wdata == e_wdata) else value_fail("wdata", retire.wdata, e_wdata);
		end
		assert (retire.next_pc == e_npc) else value_fail("next_pc", retire.next_pc, e_npc);
		if (e_wen && e_rd != 5'd0) begin
			model_regs[e_rd] = e_wdata;
		end
		model_pc = e_npc;
		retired++;
	endtask

	// the monitor samples at the rising edge and so sees the values from before the edge.
	always @(posedge clk) begin
		if (was_reset) begin
			assert (!imem_req && !retire_valid) else protocol_fail("request or retire in reset");
		end
		if (!rst_n) begin
			was_reset   = 1'b1;
			prev_req    = 1'b0;
			prev_ack    = 1'b0;
			prev_retire = 1'b0;
			prev_addr   = '0;
			pending     = 0;
			fetches     = 0;
			model_pc    = `RESET_PC;
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
		end else begin
			was_reset = 1'b0;
			if (prev_req && !imem_req) begin
				assert (prev_ack) else protocol_fail("request dropped before the ack rose");
			end
			if (prev_req && imem_req) begin
				assert (imem_addr == prev_addr) else protocol_fail("address moved during request");
			end
			if (!prev_req && imem_req) begin
				assert (!prev_ack) else protocol_fail("new request while the ack was still high");
				if (fetches == 0) begin
					assert (imem_addr == `RESET_PC)
						else value_fail("first fetch address", imem_addr, `RESET_PC);
				end
				assert (imem_addr == model_pc) else value_fail("fetch address", imem_addr, model_pc);
				fetches++;
			end
			if (prev_ack && !imem_ack) begin
				pending++;
			end
			if (retire_valid) begin
				assert (pending == 1 && !prev_retire)
					else protocol_fail("retire pulse does not match one completed fetch");
				if (pending > 0) begin
					pending--;
				end
				check_retire();
			end
			prev_req    = imem_req;
			prev_ack    = imem_ack;
			prev_addr   = imem_addr;
			prev_retire = retire_valid;
		end
	end

	// instruction memory with a random response delay and a random ack hold of 0 to 3 cycles.
	initial begin : responder
		int t;
		int delay;
		int hold;
		imem_ack   = 1'b0;
		imem_rdata = '0;
		while (!hung) begin
			t = 0;
			while (imem_req !== 1'b1 && t < WAIT_LIMIT) begin
				@(posedge clk);
				t++;
			end
			if (imem_req !== 1'b1) begin
				$display("timeout: the core made no fetch request for %0d cycles", t);
				hung = 1'b1;
			end else begin
				delay = int'(rand_bits(2));
				repeat (delay) @(posedge clk);
				fetched_inst = make_inst();
				imem_ack   <= 1'b1;
				imem_rdata <= fetched_inst;
				t = 0;
				while (imem_req !== 1'b0 && t < WAIT_LIMIT) begin
					@(posedge clk);
					t++;
				end
				if (imem_req !== 1'b0) begin
					$display("timeout: the core kept its request high after the ack");
					hung = 1'b1;
				end else begin
					// keeping the ack high a little longer holds the core back.
					hold = int'(rand_bits(2));
					repeat (hold) @(posedge clk);
					imem_ack <= 1'b0;
				end
			end
		end
	end

	initial begin
		int  cycles;
		logic run_timeout;
		rst_n = 1'b0;
		run_timeout = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		while (retired < NUM_INSTS && !hung && cycles < RUN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (!hung && retired < NUM_INSTS) begin
			$display("timeout: only %0d of %0d instructions retired", retired, NUM_INSTS);
			run_timeout = 1'b1;
		end
		$display("errors: %0d mismatches, %0d protocol failures", value_errors, protocol_errors);
		if (!hung && !run_timeout && value_errors == 0 && protocol_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+common
common/rv_isa_pkg.sv
common/core_pkg.sv
design/decode/rv_op_decoder.sv
design/decode/rv_decoder.sv
design/reg_file.sv
design/alu.sv
design/core_ctrl.sv
design/core_top.sv
test/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
